/* common/csr_cfg_pkg.sv */
`default_nettype none

/*
 * Shared widths, buffer codes and configuration word layouts for the
 * CSR index configuration loader
 */
package csr_cfg_pkg;

    // Memory response word
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int SHIFT_W    = 5;
    localparam int BUF_TYPE_W = 4;

    // Buffer types that carry configuration
    localparam logic [BUF_TYPE_W-1:0] BUF_CU_SETUP     = 4'd1;
    localparam logic [BUF_TYPE_W-1:0] BUF_ENGINE_SETUP = 4'd2;

    // Record fields
    localparam int CMD_W         = 4;
    localparam int ID_BUFFER_W   = 4;
    localparam int ID_BUFFER_LSB = 8;
    localparam int FLAGS_W       = 5;

    // Configuration sequence and engine window
    localparam int SEQ_WORDS = 16;
    localparam int SLOT_W    = $clog2(SEQ_WORDS);

    // Record FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Sum of all record field widths
    localparam int RECORD_W = FLAGS_W + 4 * DATA_W + SHIFT_W + 1 + CMD_W + BUF_TYPE_W
                            + ID_BUFFER_W;

    // One data word, read differently depending on its slot
    typedef union packed {
        logic [DATA_W-1:0] value;
        struct packed {
            logic [DATA_W-FLAGS_W-1:0] unused;
            logic                      mode_break;
            logic                      mode_buffer;
            logic                      mode_sequence;
            logic                      decrement;
            logic                      increment;
        } flags;
        struct packed {
            logic                        direction;
            logic [DATA_W-SHIFT_W-2:0]   unused;
            logic [SHIFT_W-1:0]          granularity;
        } shift;
        struct packed {
            logic [DATA_W-BUF_TYPE_W-CMD_W-1:0] unused;
            logic [BUF_TYPE_W-1:0]              buffer_type;
            logic [CMD_W-1:0]                   cmd;
        } target;
        struct packed {
            logic [DATA_W-ID_BUFFER_W-ID_BUFFER_LSB-1:0] unused_hi;
            logic [ID_BUFFER_W-1:0]                      id_buffer;
            logic [ID_BUFFER_LSB-1:0]                    unused_lo;
        } buffer;
    } cfg_word_u;

endpackage

`default_nettype wire

/* csr_index_configure.f */
+incdir+testbench
common/csr_cfg_pkg.sv
design/cfg_response_filter.sv
design/cfg_slot_tracker.sv
design/cfg_record_assembler.sv
design/cfg_record_fifo.sv
design/csr_index_configure.sv
testbench/tb_csr_index_configure.sv

/* design/cfg_record_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Record assembler. Decodes slot words 0 to 7 into configuration fields
 * and emits the packed record when the sequence completes
 */
module cfg_record_assembler
    import csr_cfg_pkg::*;
(
    input  logic                 ap_clk,
    input  logic                 areset_csr_index_generator,
    input  logic                 slot_valid,
    input  logic [SEQ_WORDS-1:0] slot_onehot,
    input  logic [DATA_W-1:0]    slot_data,
    input  logic                 seq_done,
    output logic                 record_valid,
    output logic [RECORD_W-1:0]  record_data
);

    cfg_word_u word;

    logic [FLAGS_W-1:0]     flags_r;
    logic [DATA_W-1:0]      index_start_r;
    logic [DATA_W-1:0]      index_end_r;
    logic [DATA_W-1:0]      stride_r;
    logic [SHIFT_W-1:0]     granularity_r;
    logic                   direction_r;
    logic [CMD_W-1:0]       cmd_r;
    logic [BUF_TYPE_W-1:0]  buffer_type_r;
    logic [ID_BUFFER_W-1:0] id_buffer_r;
    logic [DATA_W-1:0]      array_size_r;

    assign word = slot_data;

    // ------------------------------------------------------------------------
    // Field decode per slot
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (slot_valid) begin
            if (slot_onehot[0]) begin
                flags_r <= {word.flags.mode_break, word.flags.mode_buffer,
                            word.flags.mode_sequence, word.flags.decrement,
                            word.flags.increment};
            end
            if (slot_onehot[1]) begin
                index_start_r <= word.value;
            end
            if (slot_onehot[2]) begin
                index_end_r <= word.value;
            end
            if (slot_onehot[3]) begin
                stride_r <= word.value;
            end
            if (slot_onehot[4]) begin
                granularity_r <= word.shift.granularity;
                direction_r   <= word.shift.direction;
            end
            if (slot_onehot[5]) begin
                cmd_r         <= word.target.cmd;
                buffer_type_r <= word.target.buffer_type;
            end
            if (slot_onehot[6]) begin
                id_buffer_r <= word.buffer.id_buffer;
            end
            if (slot_onehot[7]) begin
                array_size_r <= word.value;
            end
            // Slots 8 to 15 carry no fields
        end
    end

    // ------------------------------------------------------------------------
    // Record output
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            record_valid <= 1'b0;
        end else begin
            record_valid <= seq_done;
        end
    end

    // Snapshot so a following sequence cannot disturb the pushed record
    always_ff @(posedge ap_clk) begin
        if (seq_done) begin
            record_data <= {flags_r, index_start_r, index_end_r, stride_r,
                            granularity_r, direction_r, cmd_r, buffer_type_r,
                            id_buffer_r, array_size_r};
        end
    end

endmodule

`default_nettype wire

/* design/cfg_record_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Record FIFO. Circular buffer of finished configuration records with a
 * registered read port
 */
module cfg_record_fifo
    import csr_cfg_pkg::*;
(
    input  logic                ap_clk,
    input  logic                areset_csr_index_generator,
    input  logic                record_valid,
    input  logic [RECORD_W-1:0] record_data,
    input  logic                cfg_rd_en,
    output logic                cfg_valid,
    output logic [RECORD_W-1:0] cfg_record,
    output logic                cfg_empty,
    output logic                cfg_full
);

    logic [RECORD_W-1:0]   mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;

    assign cfg_empty = (count == '0);
    assign cfg_full  = (count == FIFO_CNT_W'(FIFO_DEPTH));

    // Writes while full and reads while empty are dropped
    assign push = record_valid && !cfg_full;
    assign pop  = cfg_rd_en && !cfg_empty;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            cfg_valid <= 1'b0;
        end else begin
            cfg_valid <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= record_data;
        end
        if (pop) begin
            cfg_record <= mem[rd_ptr];
        end
    end

    a_no_write_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        record_valid |-> !cfg_full
    ) else $error("configuration record lost, record FIFO full");

endmodule

`default_nettype wire

/* design/cfg_response_filter.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Response filter. Keeps setup-type words whose sequence number falls in
 * this engine's window and tags them with their index inside it
 */
module cfg_response_filter
    import csr_cfg_pkg::*;
#(
    parameter int unsigned SEQ_BASE = 0
) (
    input  logic                  ap_clk,
    input  logic                  areset_csr_index_generator,
    input  logic                  resp_valid,
    input  logic [ADDR_W-1:0]     resp_offset,
    input  logic [SHIFT_W-1:0]    resp_shift,
    input  logic [BUF_TYPE_W-1:0] resp_buffer_type,
    input  logic [DATA_W-1:0]     resp_data,
    output logic                  word_valid,
    output logic [SLOT_W-1:0]     word_index,
    output logic [DATA_W-1:0]     word_data
);

    localparam logic [ADDR_W-1:0] SEQ_LO = ADDR_W'(SEQ_BASE);
    localparam logic [ADDR_W-1:0] SEQ_HI = ADDR_W'(SEQ_BASE + SEQ_WORDS);

    logic [ADDR_W-1:0] seq_num;
    logic              is_setup;
    logic              in_window;

    // Word offset scaled down to a sequence number
    assign seq_num   = resp_offset >> resp_shift;
    assign is_setup  = (resp_buffer_type == BUF_CU_SETUP) ||
                       (resp_buffer_type == BUF_ENGINE_SETUP);
    assign in_window = (seq_num >= SEQ_LO) && (seq_num < SEQ_HI);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= resp_valid && is_setup && in_window;
        end
    end

    // Relative index within the window
    always_ff @(posedge ap_clk) begin
        word_index <= SLOT_W'(seq_num - SEQ_LO);
        word_data  <= resp_data;
    end

endmodule

`default_nettype wire

/* design/cfg_slot_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Slot tracker. Follows a configuration sequence one-hot, one slot per
 * accepted word, and flags the last slot
 */
module cfg_slot_tracker
    import csr_cfg_pkg::*;
(
    input  logic                 ap_clk,
    input  logic                 areset_csr_index_generator,
    input  logic                 word_valid,
    input  logic [SLOT_W-1:0]    word_index,
    input  logic [DATA_W-1:0]    word_data,
    output logic                 slot_valid,
    output logic [SEQ_WORDS-1:0] slot_onehot,
    output logic [DATA_W-1:0]    slot_data,
    output logic                 seq_done
);

    // Zero while idle, otherwise the slot of the previous word
    logic [SEQ_WORDS-1:0] slot_pos;
    logic [SEQ_WORDS-1:0] next_pos;
    logic                 active;
    logic                 accept;

    assign active   = |slot_pos;
    assign next_pos = active ? (slot_pos << 1) : SEQ_WORDS'(1);
    // An idle tracker only opens on index 0
    assign accept   = word_valid && (active || (word_index == '0));

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            slot_pos    <= '0;
            slot_valid  <= 1'b0;
            slot_onehot <= '0;
            seq_done    <= 1'b0;
        end else begin
            slot_valid <= accept;
            seq_done   <= accept && next_pos[SEQ_WORDS-1];
            if (accept) begin
                slot_onehot <= next_pos;
                // Back to idle after the last slot
                slot_pos    <= next_pos[SEQ_WORDS-1] ? '0 : next_pos;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        slot_data <= word_data;
    end

    a_slot_pos_onehot0 : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        $onehot0(slot_pos)
    ) else $error("slot tracker position not one-hot: %h", slot_pos);

endmodule

`default_nettype wire

/* design/csr_index_configure.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * CSR index generator configuration loader. Filters memory responses,
 * assembles configuration records and queues them for the consumer
 */
module csr_index_configure
    import csr_cfg_pkg::*;
#(
    parameter int unsigned SEQ_BASE = 0
) (
    input  logic                   ap_clk,
    input  logic                   areset_csr_index_generator,
    input  logic                   resp_valid,
    input  logic [ADDR_W-1:0]      resp_offset,
    input  logic [SHIFT_W-1:0]     resp_shift,
    input  logic [BUF_TYPE_W-1:0]  resp_buffer_type,
    input  logic [DATA_W-1:0]      resp_data,
    input  logic                   cfg_rd_en,
    output logic                   cfg_valid,
    output logic                   cfg_empty,
    output logic                   cfg_full,
    output logic [FLAGS_W-1:0]     cfg_flags,
    output logic [DATA_W-1:0]      cfg_index_start,
    output logic [DATA_W-1:0]      cfg_index_end,
    output logic [DATA_W-1:0]      cfg_stride,
    output logic [DATA_W-1:0]      cfg_array_size,
    output logic [SHIFT_W-1:0]     cfg_granularity,
    output logic                   cfg_direction,
    output logic [CMD_W-1:0]       cfg_cmd,
    output logic [BUF_TYPE_W-1:0]  cfg_buffer_type,
    output logic [ID_BUFFER_W-1:0] cfg_id_buffer
);

    logic                 word_valid;
    logic [SLOT_W-1:0]    word_index;
    logic [DATA_W-1:0]    word_data;
    logic                 slot_valid;
    logic [SEQ_WORDS-1:0] slot_onehot;
    logic [DATA_W-1:0]    slot_data;
    logic                 seq_done;
    logic                 record_valid;
    logic [RECORD_W-1:0]  record_data;
    logic [RECORD_W-1:0]  cfg_record;

    // ------------------------------------------------------------------------
    // Response path to finished records
    // ------------------------------------------------------------------------
    cfg_response_filter #(
        .SEQ_BASE(SEQ_BASE)
    ) cfg_response_filter_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_buffer_type          (resp_buffer_type),
        .resp_data                 (resp_data),
        .word_valid                (word_valid),
        .word_index                (word_index),
        .word_data                 (word_data)
    );

    cfg_slot_tracker cfg_slot_tracker_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .word_valid                (word_valid),
        .word_index                (word_index),
        .word_data                 (word_data),
        .slot_valid                (slot_valid),
        .slot_onehot               (slot_onehot),
        .slot_data                 (slot_data),
        .seq_done                  (seq_done)
    );

    cfg_record_assembler cfg_record_assembler_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .slot_valid                (slot_valid),
        .slot_onehot               (slot_onehot),
        .slot_data                 (slot_data),
        .seq_done                  (seq_done),
        .record_valid              (record_valid),
        .record_data               (record_data)
    );

    cfg_record_fifo cfg_record_fifo_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .record_valid              (record_valid),
        .record_data               (record_data),
        .cfg_rd_en                 (cfg_rd_en),
        .cfg_valid                 (cfg_valid),
        .cfg_record                (cfg_record),
        .cfg_empty                 (cfg_empty),
        .cfg_full                  (cfg_full)
    );

    // Same field order as the assembler packs
    assign {cfg_flags, cfg_index_start, cfg_index_end, cfg_stride,
            cfg_granularity, cfg_direction, cfg_cmd, cfg_buffer_type,
            cfg_id_buffer, cfg_array_size} = cfg_record;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_csr_index_configure \
    -f csr_index_configure.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_csr_index_configure > sim.log 2>&1

grep -q '^TEST OK$' sim.log \
    && echo "simulation passed, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* testbench/tb_cfg_tasks.svh */
/*
 * Testbench tasks that drive response words, send configuration
 * sequences and pop records from the DUT
 */
`ifndef TB_CFG_TASKS_SVH
`define TB_CFG_TASKS_SVH

// One response word, offset scaled up by a random shift
task automatic send_word(input logic [ADDR_W-1:0] seq, input logic [BUF_TYPE_W-1:0] btype,
                         input logic [DATA_W-1:0] data);
    int unsigned shift;
    shift = $urandom_range(0, 3);
    @(posedge ap_clk);
    #1;
    resp_valid       = 1'b1;
    resp_offset      = seq << shift;
    resp_shift       = SHIFT_W'(shift);
    resp_buffer_type = btype;
    resp_data        = data;
endtask

task automatic bus_idle();
    @(posedge ap_clk);
    #1;
    resp_valid = 1'b0;
endtask

// Random slot word with a few fields set through their views
function automatic logic [DATA_W-1:0] make_slot_word(input int slot,
                                                     input logic [BUF_TYPE_W-1:0] btype);
    cfg_word_u w;
    w.value = $urandom;
    case (slot)
        0: w.flags.mode_sequence = 1'b1;
        4: w.shift.granularity = SHIFT_W'($urandom_range(0, 16));
        5: w.target.buffer_type = btype;
        default: ;
    endcase
    return w.value;
endfunction

// Full 16-word sequence, optionally mixed with words the filter must drop
task automatic send_sequence(input logic [BUF_TYPE_W-1:0] btype, input bit mixed);
    logic [DATA_W-1:0] w;
    for (int slot = 0; slot < SEQ_WORDS; slot++) begin
        w = make_slot_word(slot, btype);
        if (slot < FIELD_SLOTS) begin
            exp_words.push_back(w);
        end
        if (mixed) begin
            send_word(ADDR_W'(slot), BUF_TYPE_W'($urandom_range(3, 15)), $urandom);
            send_word(ADDR_W'($urandom_range(SEQ_WORDS, 2 * SEQ_WORDS - 1)), btype, $urandom);
        end
        send_word(ADDR_W'(slot), btype, w);
    end
    bus_idle();
endtask

task automatic wait_record();
    int n;
    n = 0;
    while (cfg_empty && n < RECORD_WAIT) begin
        @(negedge ap_clk);
        n++;
    end
    assert (!cfg_empty) else begin
        $display("no record reached the FIFO within %0d cycles", RECORD_WAIT);
        errors++;
    end
endtask

// Single-cycle pop, returns once the popped record has been checked
task automatic pop_record();
    @(posedge ap_clk);
    #1;
    cfg_rd_en = 1'b1;
    @(posedge ap_clk);
    #1;
    cfg_rd_en = 1'b0;
    @(negedge ap_clk);
    #1;
endtask

`endif

/* testbench/tb_csr_index_configure.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Testbench for the CSR index configuration loader
 */
module tb_csr_index_configure
    import csr_cfg_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int FIELD_SLOTS    = 8;
    localparam int RECORD_WAIT    = 50;

    logic                   ap_clk;
    logic                   areset_csr_index_generator;
    logic                   resp_valid;
    logic [ADDR_W-1:0]      resp_offset;
    logic [SHIFT_W-1:0]     resp_shift;
    logic [BUF_TYPE_W-1:0]  resp_buffer_type;
    logic [DATA_W-1:0]      resp_data;
    logic                   cfg_rd_en;
    logic                   cfg_valid;
    logic                   cfg_empty;
    logic                   cfg_full;
    logic [FLAGS_W-1:0]     cfg_flags;
    logic [DATA_W-1:0]      cfg_index_start;
    logic [DATA_W-1:0]      cfg_index_end;
    logic [DATA_W-1:0]      cfg_stride;
    logic [DATA_W-1:0]      cfg_array_size;
    logic [SHIFT_W-1:0]     cfg_granularity;
    logic                   cfg_direction;
    logic [CMD_W-1:0]       cfg_cmd;
    logic [BUF_TYPE_W-1:0]  cfg_buffer_type;
    logic [ID_BUFFER_W-1:0] cfg_id_buffer;

    // Slot 0 to 7 words of every record still expected, oldest first
    logic [DATA_W-1:0] exp_words[$];
    int                errors = 0;
    int                errors_at_start = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;
    int                cycles = 0;

    csr_index_configure #(
        .SEQ_BASE(0)
    ) csr_index_configure_i (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_buffer_type          (resp_buffer_type),
        .resp_data                 (resp_data),
        .cfg_rd_en                 (cfg_rd_en),
        .cfg_valid                 (cfg_valid),
        .cfg_empty                 (cfg_empty),
        .cfg_full                  (cfg_full),
        .cfg_flags                 (cfg_flags),
        .cfg_index_start           (cfg_index_start),
        .cfg_index_end             (cfg_index_end),
        .cfg_stride                (cfg_stride),
        .cfg_array_size            (cfg_array_size),
        .cfg_granularity           (cfg_granularity),
        .cfg_direction             (cfg_direction),
        .cfg_cmd                   (cfg_cmd),
        .cfg_buffer_type           (cfg_buffer_type),
        .cfg_id_buffer             (cfg_id_buffer)
    );

    initial begin
        ap_clk = 1'b0;
    end

    always #4 ap_clk = ~ap_clk;

    `include "tb_cfg_tasks.svh"

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------
    task automatic check_field(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] expected);
        assert (got == expected) else begin
            $display("FAILED %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Fields decoded from the words sent, per slot
    task automatic check_record();
        cfg_word_u w [FIELD_SLOTS];
        assert (exp_words.size() >= FIELD_SLOTS) else begin
            $display("record popped while none was expected");
            errors++;
        end
        if (exp_words.size() >= FIELD_SLOTS) begin
            for (int i = 0; i < FIELD_SLOTS; i++) begin
                w[i] = exp_words.pop_front();
            end
            check_field("cfg_flags", 32'(cfg_flags), 32'(w[0].value[FLAGS_W-1:0]));
            check_field("cfg_index_start", cfg_index_start, w[1].value);
            check_field("cfg_index_end", cfg_index_end, w[2].value);
            check_field("cfg_stride", cfg_stride, w[3].value);
            check_field("cfg_granularity", 32'(cfg_granularity), 32'(w[4].shift.granularity));
            check_field("cfg_direction", 32'(cfg_direction), 32'(w[4].shift.direction));
            check_field("cfg_cmd", 32'(cfg_cmd), 32'(w[5].target.cmd));
            check_field("cfg_buffer_type", 32'(cfg_buffer_type), 32'(w[5].target.buffer_type));
            check_field("cfg_id_buffer", 32'(cfg_id_buffer), 32'(w[6].buffer.id_buffer));
            check_field("cfg_array_size", cfg_array_size, w[7].value);
        end
    endtask

    always @(negedge ap_clk) begin
        if (cfg_valid) begin
            check_record();
        end
    end

    // No record left over and none pending
    task automatic confirm_drained();
        repeat (8) @(negedge ap_clk);
        assert (exp_words.size() == 0) else begin
            $display("%0d expected records never came out", exp_words.size() / FIELD_SLOTS);
            errors++;
        end
        check_field("cfg_empty", 32'(cfg_empty), 32'd1);
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", name, errors - errors_at_start);
        end
    endtask

    always @(posedge ap_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h3129));
        areset_csr_index_generator = 1'b1;
        resp_valid       = 1'b0;
        resp_offset      = '0;
        resp_shift       = '0;
        resp_buffer_type = '0;
        resp_data        = '0;
        cfg_rd_en        = 1'b0;
        repeat (3) @(posedge ap_clk);
        #1;
        areset_csr_index_generator = 1'b0;

        start_test();
        @(negedge ap_clk);
        check_field("cfg_valid", 32'(cfg_valid), 32'd0);
        check_field("cfg_empty", 32'(cfg_empty), 32'd1);
        check_field("cfg_full", 32'(cfg_full), 32'd0);
        end_test("reset state");

        start_test();
        send_sequence(BUF_CU_SETUP, 1'b0);
        wait_record();
        pop_record();
        confirm_drained();
        end_test("cu setup sequence");

        // Other buffer types and out-of-window words between the real ones
        start_test();
        send_sequence(BUF_ENGINE_SETUP, 1'b1);
        wait_record();
        pop_record();
        confirm_drained();
        end_test("engine setup with filtered words");

        start_test();
        for (int i = 1; i < SEQ_WORDS; i += 4) begin
            send_word(ADDR_W'(i), BUF_CU_SETUP, $urandom);
        end
        bus_idle();
        send_sequence(BUF_CU_SETUP, 1'b0);
        wait_record();
        pop_record();
        confirm_drained();
        end_test("idle words with nonzero index");

        start_test();
        send_sequence(BUF_CU_SETUP, 1'b0);
        send_sequence(BUF_ENGINE_SETUP, 1'b0);
        send_sequence(BUF_CU_SETUP, 1'b0);
        repeat (3) begin
            wait_record();
            pop_record();
        end
        confirm_drained();
        end_test("three queued records");

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
